// ==== cache_types.sv ====
`default_nettype none

package cache_types;

    localparam int tag_width    = 23;
    localparam int index_width  = 4;
    localparam int offset_width = 5;
    localparam int num_sets     = 1 << index_width;

    typedef logic [tag_width-1:0]    tag_t;
    typedef logic [index_width-1:0]  index_t;
    typedef logic [offset_width-1:0] offset_t;
    typedef logic [1:0]              way_t;
    typedef logic [2:0]              plru_t;     // [0] root, [1] ways 0/1, [2] ways 2/3.

    typedef struct packed {
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    typedef struct packed {
        logic [31:0] addr;
        tag_t        tag;
        index_t      index;
        offset_t     offset;
        logic [3:0]  rmask;
        logic [3:0]  wmask;
        logic [31:0] wdata;
    } stage_reg_t;

    // root clear sends the victim to the right pair.
    function automatic way_t victim_way(plru_t lru);
        if (lru[0]) begin
            return {1'b0, ~lru[1]};
        end
        return {1'b1, ~lru[2]};
    endfunction

endpackage : cache_types

`default_nettype wire

// ==== dfp_types.sv ====
`default_nettype none

package dfp_types;

    localparam int line_bits = 256;

    typedef logic [line_bits-1:0] line_t;

    // request levels stay up until resp.
    typedef struct packed {
        logic [31:0] addr;
        logic        read;
        logic        write;
        line_t       wdata;
    } dfp_req_t;

    typedef struct packed {
        logic  resp;
        line_t rdata;
    } dfp_rsp_t;

endpackage : dfp_types

`default_nettype wire

// ==== cache_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_array #(
    parameter type entry_t = logic,
    parameter int  depth   = cache_types::num_sets
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                web,
    input  cache_types::index_t waddr,
    input  entry_t              wdata,
    input  cache_types::index_t raddr,
    output entry_t              rdata
);

    entry_t mem [depth];

    ////////////////////////////////////////////////////////////
    // write port
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!web) begin
            mem[waddr] <= wdata;      // active low.
        end
    end

    ////////////////////////////////////////////////////////////
    // read port
    ////////////////////////////////////////////////////////////

    // same-set write in this cycle shows up one edge later.
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata <= '0;
        end else begin
            rdata <= mem[raddr];
        end
    end

endmodule : cache_array

`default_nettype wire

// ==== cache_stage_1.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_stage_1 #(
    parameter int num_ways = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [31:0]             ufp_addr,
    input  logic [3:0]              ufp_rmask,
    input  logic [3:0]              ufp_wmask,
    input  logic [31:0]             ufp_wdata,
    input  logic                    read_halt,
    input  logic                    write_halt,
    input  logic                    dirty_halt,
    input  cache_types::way_t       write_way,
    input  cache_types::plru_t      lru_read,
    input  dfp_types::dfp_rsp_t     dfp_rsp,
    input  dfp_types::line_t        data_old,
    output cache_types::stage_reg_t stage_reg,
    output cache_types::index_t     rindex,
    output logic [num_ways-1:0]     data_web,
    output logic [num_ways-1:0]     tag_web,
    output logic [num_ways-1:0]     valid_set,
    output dfp_types::line_t        line_wdata,
    output cache_types::tag_entry_t tag_wdata,
    output logic                    dfp_resp_reg,
    output logic                    dfp_switch_reg,
    output logic                    write_done_reg,
    output logic                    dfp_write_read
);

    cache_types::stage_reg_t req_q;
    dfp_types::line_t        refill_q;
    dfp_types::line_t        merged;
    cache_types::way_t       victim;
    logic                    busy;
    logic                    armed;      // arrays hold data for req_q.
    logic                    load;
    logic                    done;
    logic                    wb_resp;
    logic                    rd_resp;
    logic                    refill_wr;

    assign victim    = cache_types::victim_way(lru_read);
    assign load      = !busy && !(read_halt || write_halt || dirty_halt)
                       && (|ufp_rmask || |ufp_wmask);
    assign done      = armed && !read_halt && !write_done_reg;
    assign wb_resp   = dfp_rsp.resp && dirty_halt;
    assign rd_resp   = dfp_rsp.resp && read_halt && !dirty_halt;
    assign refill_wr = dfp_resp_reg && dfp_write_read;
    assign rindex    = req_q.index;

    always_comb begin
        stage_reg = req_q;
        if (!armed) begin
            stage_reg.rmask = '0;
            stage_reg.wmask = '0;
        end
    end

    ////////////////////////////////////////////////////////////
    // request and miss sequencing
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            busy           <= 1'b0;
            armed          <= 1'b0;
            dfp_resp_reg   <= 1'b0;
            dfp_switch_reg <= 1'b0;
            write_done_reg <= 1'b0;
            dfp_write_read <= 1'b0;
        end else begin
            dfp_resp_reg   <= dfp_rsp.resp;
            write_done_reg <= refill_wr || write_halt;
            if (wb_resp) begin
                dfp_switch_reg <= 1'b1;      // write-back done so switch to read.
            end else if (refill_wr) begin
                dfp_switch_reg <= 1'b0;
            end
            if (rd_resp) begin
                dfp_write_read <= 1'b1;
            end else if (refill_wr) begin
                dfp_write_read <= 1'b0;
            end
            if (load) begin
                busy  <= 1'b1;
                armed <= 1'b0;
            end else if (done) begin
                busy  <= 1'b0;
                armed <= 1'b0;
            end else begin
                armed <= busy;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            req_q.addr   <= ufp_addr;
            req_q.tag    <= ufp_addr[31:9];
            req_q.index  <= ufp_addr[8:5];
            req_q.offset <= ufp_addr[4:0];
            req_q.rmask  <= ufp_rmask;
            req_q.wmask  <= ufp_wmask;
            req_q.wdata  <= ufp_wdata;
        end
        if (rd_resp) begin
            refill_q <= dfp_rsp.rdata;
        end
    end

    ////////////////////////////////////////////////////////////
    // array writes
    ////////////////////////////////////////////////////////////

    always_comb begin
        merged = data_old;
        for (int b = 0; b < 4; b++) begin
            if (req_q.wmask[b]) begin
                merged[32*req_q.offset[4:2] + 8*b +: 8] = req_q.wdata[8*b +: 8];
            end
        end
    end

    always_comb begin
        data_web        = '1;
        tag_web         = '1;
        valid_set       = '0;
        line_wdata      = merged;
        tag_wdata.dirty = 1'b1;
        tag_wdata.tag   = req_q.tag;
        if (refill_wr) begin
            data_web[victim]  = 1'b0;
            tag_web[victim]   = 1'b0;
            valid_set[victim] = 1'b1;
            line_wdata        = refill_q;
            tag_wdata.dirty   = 1'b0;        // fresh line is clean.
        end else if (write_halt) begin
            data_web[write_way] = 1'b0;
            tag_web[write_way]  = 1'b0;
        end
    end

endmodule : cache_stage_1

`default_nettype wire

// ==== cache_stage_2.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_stage_2 #(
    parameter int num_ways = 4
) (
    input  logic                    rst,
    input  cache_types::stage_reg_t stage_reg,
    input  logic                    valid_out [num_ways],
    input  cache_types::tag_entry_t tag_out [num_ways],
    input  dfp_types::line_t        data_out [num_ways],
    input  cache_types::plru_t      lru_read,
    input  logic                    dfp_resp_reg,
    input  logic                    dfp_switch_reg,
    input  logic                    write_done_reg,
    input  logic                    dfp_write_read,
    output dfp_types::dfp_req_t     dfp_req,
    output logic                    ufp_resp,
    output logic [31:0]             ufp_rdata,
    output cache_types::plru_t      lru_write,
    output logic                    lru_web,
    output logic                    read_halt,
    output logic                    write_halt,
    output logic                    dirty_halt,
    output cache_types::way_t       write_way
);

    logic              active;
    logic              hit;
    cache_types::way_t hit_way;
    cache_types::way_t victim;
    logic              victim_dirty;
    logic [31:0]       rmask_ext;
    logic [7:0]        word_base;

    assign active       = (|stage_reg.rmask || |stage_reg.wmask) && !write_done_reg;
    assign victim       = cache_types::victim_way(lru_read);
    assign victim_dirty = valid_out[victim] && tag_out[victim].dirty;
    assign word_base    = {stage_reg.offset[4:2], 5'b00000};

    ////////////////////////////////////////////////////////////
    // tag compare
    ////////////////////////////////////////////////////////////

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int i = 0; i < num_ways; i++) begin
            if (valid_out[i] && tag_out[i].tag == stage_reg.tag) begin
                hit     = 1'b1;
                hit_way = cache_types::way_t'(i);
            end
        end
    end

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            rmask_ext[8*b +: 8] = {8{stage_reg.rmask[b]}};
        end
    end

    ////////////////////////////////////////////////////////////
    // response and miss handling
    ////////////////////////////////////////////////////////////

    always_comb begin
        dfp_req.addr  = {stage_reg.addr[31:5], 5'b00000};
        dfp_req.read  = 1'b0;
        dfp_req.write = 1'b0;
        dfp_req.wdata = '0;
        ufp_resp      = 1'b0;
        ufp_rdata     = '0;
        lru_write     = lru_read;
        lru_web       = 1'b1;
        read_halt     = 1'b0;
        write_halt    = 1'b0;
        dirty_halt    = 1'b0;
        write_way     = '0;

        if (rst) begin
            dfp_req.addr = '0;
        end else if (active) begin
            if (hit) begin
                ufp_resp   = 1'b1;
                ufp_rdata  = data_out[hit_way][word_base +: 32] & rmask_ext;
                write_halt = |stage_reg.wmask;     // merge on next edge.
                write_way  = hit_way;

                // point the tree away from the way just used.
                lru_write[0]              = hit_way[1];
                lru_write[1 + hit_way[1]] = hit_way[0];
                lru_web                   = 1'b0;
            end else begin
                read_halt = 1'b1;
                if (!dfp_write_read) begin
                    if (victim_dirty && !dfp_switch_reg) begin
                        dirty_halt         = 1'b1;
                        dfp_req.write      = 1'b1;
                        dfp_req.addr[31:9] = tag_out[victim].tag;
                        dfp_req.wdata      = data_out[victim];
                    end else begin
                        dfp_req.read = !dfp_resp_reg;  // idle one cycle after resp.
                    end
                end
            end
        end
    end

endmodule : cache_stage_2

`default_nettype wire

// ==== cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache #(
    parameter int num_ways = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [31:0]         ufp_addr,
    input  logic [3:0]          ufp_rmask,
    input  logic [3:0]          ufp_wmask,
    input  logic [31:0]         ufp_wdata,
    output logic [31:0]         ufp_rdata,
    output logic                ufp_resp,
    output dfp_types::dfp_req_t dfp_req,
    input  dfp_types::dfp_rsp_t dfp_rsp
);

    cache_types::stage_reg_t stage_reg;
    cache_types::index_t     rindex;
    logic [num_ways-1:0]     data_web;
    logic [num_ways-1:0]     tag_web;
    logic [num_ways-1:0]     valid_set;
    dfp_types::line_t        line_wdata;
    cache_types::tag_entry_t tag_wdata;
    logic                    dfp_resp_reg;
    logic                    dfp_switch_reg;
    logic                    write_done_reg;
    logic                    dfp_write_read;
    logic                    read_halt;
    logic                    write_halt;
    logic                    dirty_halt;
    cache_types::way_t       write_way;
    cache_types::plru_t      lru_read;
    cache_types::plru_t      lru_write;
    logic                    lru_web;
    logic                    valid_out [num_ways];
    cache_types::tag_entry_t tag_out [num_ways];
    dfp_types::line_t        data_out [num_ways];
    dfp_types::line_t        data_old;

    assign data_old = data_out[write_way];     // line under merge.

    cache_stage_1 #(.num_ways(num_ways)) stage_1 (
        .clk(clk), .rst(rst),
        .ufp_addr(ufp_addr), .ufp_rmask(ufp_rmask),
        .ufp_wmask(ufp_wmask), .ufp_wdata(ufp_wdata),
        .read_halt(read_halt), .write_halt(write_halt), .dirty_halt(dirty_halt),
        .write_way(write_way), .lru_read(lru_read),
        .dfp_rsp(dfp_rsp), .data_old(data_old),
        .stage_reg(stage_reg), .rindex(rindex),
        .data_web(data_web), .tag_web(tag_web), .valid_set(valid_set),
        .line_wdata(line_wdata), .tag_wdata(tag_wdata),
        .dfp_resp_reg(dfp_resp_reg), .dfp_switch_reg(dfp_switch_reg),
        .write_done_reg(write_done_reg), .dfp_write_read(dfp_write_read)
    );

    cache_stage_2 #(.num_ways(num_ways)) stage_2 (
        .rst(rst), .stage_reg(stage_reg),
        .valid_out(valid_out), .tag_out(tag_out), .data_out(data_out),
        .lru_read(lru_read),
        .dfp_resp_reg(dfp_resp_reg), .dfp_switch_reg(dfp_switch_reg),
        .write_done_reg(write_done_reg), .dfp_write_read(dfp_write_read),
        .dfp_req(dfp_req), .ufp_resp(ufp_resp), .ufp_rdata(ufp_rdata),
        .lru_write(lru_write), .lru_web(lru_web),
        .read_halt(read_halt), .write_halt(write_halt), .dirty_halt(dirty_halt),
        .write_way(write_way)
    );

    ////////////////////////////////////////////////////////////
    // per-way storage
    ////////////////////////////////////////////////////////////

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        logic [cache_types::num_sets-1:0] valid_bits;

        cache_array #(
            .entry_t(dfp_types::line_t),
            .depth(cache_types::num_sets)
        ) data_array (
            .clk(clk), .rst(rst), .web(data_web[w]),
            .waddr(stage_reg.index), .wdata(line_wdata),
            .raddr(rindex), .rdata(data_out[w])
        );

        cache_array #(
            .entry_t(cache_types::tag_entry_t),
            .depth(cache_types::num_sets)
        ) tag_array (
            .clk(clk), .rst(rst), .web(tag_web[w]),
            .waddr(stage_reg.index), .wdata(tag_wdata),
            .raddr(rindex), .rdata(tag_out[w])
        );

        // read timing matches the arrays.
        always_ff @(posedge clk) begin
            if (rst) begin
                valid_bits   <= '0;
                valid_out[w] <= 1'b0;
            end else begin
                if (valid_set[w]) begin
                    valid_bits[stage_reg.index] <= 1'b1;
                end
                valid_out[w] <= valid_bits[rindex];
            end
        end
    end

    cache_array #(
        .entry_t(cache_types::plru_t),
        .depth(cache_types::num_sets)
    ) lru_array (
        .clk(clk), .rst(rst), .web(lru_web),
        .waddr(stage_reg.index), .wdata(lru_write),
        .raddr(rindex), .rdata(lru_read)
    );

endmodule : cache

`default_nettype wire

// ==== tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int half_period  = 10,
    parameter int reset_cycles = 16
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b1;                      // first edge is a falling one.
        forever #half_period clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule : tb_clock

`default_nettype wire

// ==== tb_line_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_line_memory (
    input  logic                clk,
    input  logic                rst,
    input  dfp_types::dfp_req_t dfp_req,
    output dfp_types::dfp_rsp_t dfp_rsp,
    output int                  read_count,
    output int                  write_count,
    output logic [31:0]         last_raddr,
    output logic [31:0]         last_waddr,
    output dfp_types::line_t    last_wdata
);

    dfp_types::line_t lines [256];    // shadow image of 8 KB.
    logic             busy;
    int               wait_left;
    logic [7:0]       line_idx;

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
    endfunction

    initial begin
        for (int l = 0; l < 256; l++) begin
            for (int w = 0; w < 8; w++) begin
                lines[l][32*w +: 32] = fill_word(32'(l * 32 + w * 4));
            end
        end
    end

    assign line_idx = dfp_req.addr[12:5];

    always @(negedge clk) begin
        if (rst) begin
            dfp_rsp     <= '0;
            busy        <= 1'b0;
            wait_left   <= 0;
            read_count  <= 0;
            write_count <= 0;
            last_raddr  <= '0;
            last_waddr  <= '0;
            last_wdata  <= '0;
        end else if (dfp_rsp.resp) begin
            dfp_rsp.resp <= 1'b0;         // one-cycle pulse.
        end else if (!busy) begin
            if (dfp_req.read || dfp_req.write) begin
                busy      <= 1'b1;
                wait_left <= int'($urandom_range(8, 1));
            end
        end else if (wait_left > 1) begin
            wait_left <= wait_left - 1;
        end else begin
            busy         <= 1'b0;
            dfp_rsp.resp <= 1'b1;
            if (dfp_req.write) begin
                lines[line_idx] <= dfp_req.wdata;
                write_count     <= write_count + 1;
                last_waddr      <= dfp_req.addr;
                last_wdata      <= dfp_req.wdata;
            end else begin
                dfp_rsp.rdata <= lines[line_idx];
                read_count    <= read_count + 1;
                last_raddr    <= dfp_req.addr;
            end
        end
    end

endmodule : tb_line_memory

`default_nettype wire

// ==== tb_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cache;

    localparam int num_ways     = 4;
    localparam int num_requests = 400;                // total over all tests rounded up.
    localparam int cycle_limit  = 16 + num_requests * 50;

    logic                clk;
    logic                rst;
    logic [31:0]         ufp_addr;
    logic [3:0]          ufp_rmask;
    logic [3:0]          ufp_wmask;
    logic [31:0]         ufp_wdata;
    logic [31:0]         ufp_rdata;
    logic                ufp_resp;
    dfp_types::dfp_req_t dfp_req;
    dfp_types::dfp_rsp_t dfp_rsp;
    int                  read_count;
    int                  write_count;
    logic [31:0]         last_raddr;
    logic [31:0]         last_waddr;
    dfp_types::line_t    last_wdata;

    // reference model of the line image and per-set state.
    dfp_types::line_t   model_img [256];
    dfp_types::line_t   start_img [256];
    logic               model_valid [16][num_ways];
    logic               model_dirty [16][num_ways];
    cache_types::tag_t  model_tag [16][num_ways];
    cache_types::plru_t model_plru [16];

    int   errors = 0;
    int   tests_run = 0;
    int   tests_failed = 0;
    int   cycles = 0;
    logic started = 1'b0;

    tb_clock clock_gen (.clk(clk), .rst(rst));

    tb_line_memory line_mem (
        .clk(clk), .rst(rst), .dfp_req(dfp_req), .dfp_rsp(dfp_rsp),
        .read_count(read_count), .write_count(write_count),
        .last_raddr(last_raddr), .last_waddr(last_waddr), .last_wdata(last_wdata)
    );

    cache #(.num_ways(num_ways)) uut (
        .clk(clk), .rst(rst),
        .ufp_addr(ufp_addr), .ufp_rmask(ufp_rmask), .ufp_wmask(ufp_wmask),
        .ufp_wdata(ufp_wdata), .ufp_rdata(ufp_rdata), .ufp_resp(ufp_resp),
        .dfp_req(dfp_req), .dfp_rsp(dfp_rsp)
    );

    ////////////////////////////////////////////////////////////
    // protocol properties
    ////////////////////////////////////////////////////////////

    quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
        !started |-> !ufp_resp && !dfp_req.read && !dfp_req.write)
        else begin
            errors++;
            $display("cache became active before the first request");
        end

    one_dfp_op: assert property (@(posedge clk) disable iff (rst)
        !(dfp_req.read && dfp_req.write))
        else begin
            errors++;
            $display("dfp read and write raised together");
        end

    line_aligned: assert property (@(posedge clk) disable iff (rst)
        (dfp_req.read || dfp_req.write) |-> dfp_req.addr[4:0] == 5'd0
        && dfp_req.addr[31:13] == 19'd0)
        else begin
            errors++;
            $display("dfp address %h is unaligned or outside memory", dfp_req.addr);
        end

    resp_pulse: assert property (@(posedge clk) disable iff (rst) ufp_resp |=> !ufp_resp)
        else begin
            errors++;
            $display("ufp_resp held longer than one cycle");
        end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("run stopped by timeout after %0d cycles", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] make_addr(input int tag, input int set, input int word);
        return {19'd0, 4'(tag), 4'(set), 3'(word), 2'b00};
    endfunction

    function automatic logic [31:0] byte_mask(input logic [3:0] m);
        logic [31:0] r;
        for (int b = 0; b < 4; b++) begin
            r[8*b +: 8] = {8{m[b]}};
        end
        return r;
    endfunction

    // root set means the left pair is older.
    function automatic int plru_victim(input cache_types::plru_t p);
        if (p[0]) begin
            return p[1] ? 0 : 1;
        end
        return p[2] ? 2 : 3;
    endfunction

    task automatic check_eq(input string name, input logic [255:0] got,
                            input logic [255:0] exp);
        assert (got == exp) else begin
            errors++;
            $display("error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests_run++;
        if (errors != errors_before) begin
            tests_failed++;
            $display("%s: failed", name);
        end else begin
            $display("%s: ok", name);
        end
    endtask

    // one request through the model and the DUT.
    task automatic access(input logic [31:0] addr, input logic [3:0] rmask,
                          input logic [3:0] wmask, input logic [31:0] wdata,
                          output int latency);
        int               set_i;
        int               li;
        int               word_i;
        int               h;
        int               reads0;
        int               writes0;
        int               writes_at_read;
        logic             hit;
        logic             wb;
        logic [31:0]      wb_addr;
        logic [31:0]      exp_rdata;
        dfp_types::line_t wb_line;
        set_i   = int'(addr[8:5]);
        li      = int'(addr[12:5]);
        word_i  = int'(addr[4:2]);
        hit     = 1'b0;
        wb      = 1'b0;
        h       = 0;
        wb_addr = '0;
        wb_line = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (model_valid[set_i][w] && model_tag[set_i][w] == addr[31:9]) begin
                hit = 1'b1;
                h   = w;
            end
        end
        if (!hit) begin
            h = plru_victim(model_plru[set_i]);
            if (model_valid[set_i][h] && model_dirty[set_i][h]) begin
                wb      = 1'b1;
                wb_addr = {model_tag[set_i][h], addr[8:5], 5'd0};
                wb_line = model_img[int'(wb_addr[12:5])];
            end
            model_valid[set_i][h] = 1'b1;
            model_tag[set_i][h]   = addr[31:9];
            model_dirty[set_i][h] = 1'b0;
        end
        exp_rdata = model_img[li][32*word_i +: 32] & byte_mask(rmask);
        for (int b = 0; b < 4; b++) begin
            if (wmask[b]) begin
                model_img[li][32*word_i + 8*b +: 8] = wdata[8*b +: 8];
            end
        end
        if (|wmask) begin
            model_dirty[set_i][h] = 1'b1;
        end
        model_plru[set_i][0] = (h >= 2);
        if (h < 2) begin
            model_plru[set_i][1] = (h == 1);
        end else begin
            model_plru[set_i][2] = (h == 3);
        end

        @(negedge clk);
        reads0         = read_count;
        writes0        = write_count;
        started        = 1'b1;
        ufp_addr       = addr;
        ufp_rmask      = rmask;
        ufp_wmask      = wmask;
        ufp_wdata      = wdata;
        latency        = 0;
        writes_at_read = -1;
        do begin
            @(negedge clk);
            latency++;
            if (writes_at_read < 0 && read_count != reads0) begin
                writes_at_read = write_count;     // writes done when the refill came back.
            end
        end while (!ufp_resp);
        check_eq("ufp_rdata", 256'(ufp_rdata), 256'(exp_rdata));
        ufp_rmask = '0;
        ufp_wmask = '0;

        check_eq("dfp read count", 256'(read_count - reads0), 256'(hit ? 0 : 1));
        check_eq("dfp write count", 256'(write_count - writes0), 256'(wb ? 1 : 0));
        if (!hit) begin
            check_eq("dfp read addr", 256'(last_raddr), 256'({addr[31:5], 5'd0}));
        end
        if (wb) begin
            check_eq("dfp write addr", 256'(last_waddr), 256'(wb_addr));
            check_eq("dfp write data", last_wdata, wb_line);
            check_eq("dfp writes before read", 256'(writes_at_read - writes0), 256'(1));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    initial begin
        int          lat;
        int          errs;
        int          writes0;
        int          flush_sets [5];
        logic [31:0] addr;
        flush_sets = '{2, 3, 7, 9, 12};
        ufp_addr   = '0;
        ufp_rmask  = '0;
        ufp_wmask  = '0;
        ufp_wdata  = '0;
        void'($urandom(32'h6009d1db));
        for (int s = 0; s < 16; s++) begin
            model_plru[s] = '0;
            for (int w = 0; w < num_ways; w++) begin
                model_valid[s][w] = 1'b0;
                model_dirty[s][w] = 1'b0;
                model_tag[s][w]   = '0;
            end
        end
        @(negedge rst);
        for (int l = 0; l < 256; l++) begin
            model_img[l] = line_mem.lines[l];
            start_img[l] = line_mem.lines[l];
        end

        errs = errors;
        repeat (8) @(negedge clk);
        end_test("test 1 idle after reset", errs);

        errs = errors;
        access(make_addr(0, 2, 2), 4'b1111, 4'b0000, '0, lat);
        access(make_addr(0, 2, 5), 4'b0110, 4'b0000, '0, lat);
        end_test("test 2 read miss", errs);

        errs = errors;
        access(make_addr(0, 2, 3), 4'b1100, 4'b0000, '0, lat);
        check_eq("hit latency", 256'(lat), 256'(2));
        end_test("test 3 read hit", errs);

        errs = errors;
        access(make_addr(0, 2, 2), 4'b0000, 4'b0011, 32'ha5a5_1234, lat);
        access(make_addr(0, 2, 2), 4'b1111, 4'b0000, '0, lat);
        check_eq("memory line 2", line_mem.lines[2], start_img[2]);
        end_test("test 4 write hit", errs);

        errs    = errors;
        writes0 = write_count;
        for (int t = 1; t <= 4; t++) begin
            access(make_addr(t, 9, t), 4'b0000, 4'b1111, 32'hc0de_0000 + 32'(t), lat);
        end
        access(make_addr(5, 9, 0), 4'b1111, 4'b0000, '0, lat);
        check_eq("dfp write count", 256'(write_count - writes0), 256'(1));
        end_test("test 5 eviction", errs);

        errs = errors;
        for (int n = 0; n < 300; n++) begin
            addr = make_addr(int'($urandom_range(6, 1)), flush_sets[$urandom_range(3, 1)],
                             int'($urandom_range(7, 0)));
            if ($urandom_range(1, 0) == 1) begin
                access(addr, 4'b0000, 4'($urandom_range(15, 1)), $urandom, lat);
            end else begin
                access(addr, 4'($urandom_range(15, 1)), 4'b0000, '0, lat);
            end
        end
        // fresh tags push every dirty line out.
        foreach (flush_sets[i]) begin
            for (int t = 12; t < 16; t++) begin
                access(make_addr(t, flush_sets[i], 0), 4'b1111, 4'b0000, '0, lat);
            end
        end
        for (int l = 0; l < 256; l++) begin
            check_eq($sformatf("memory line %0d", l), line_mem.lines[l], model_img[l]);
        end
        end_test("test 6 random and flush", errs);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : tb_cache

`default_nettype wire

// ==== cache.f ====
cache_types.sv
dfp_types.sv
cache_array.sv
cache_stage_1.sv
cache_stage_2.sv
cache.sv
tb_clock.sv
tb_line_memory.sv
tb_cache.sv

// ==== Makefile ====
# Verilator build and run for the cache testbench.

VERILATOR ?= verilator
TOP       ?= tb_cache
FILELIST  ?= cache.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Finished with no errors

SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
